//--- build.f
+incdir+bench
common/trap_pkg.sv
hdl/commit_decode.sv
csr/csr_file.sv
hdl/trap_redirect.sv
hdl/trap_unit.sv
bench/trap_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module trap_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtrap_unit_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "simulation did not pass"
exit 1

//--- bench/trap_unit_table.svh
//////////////////////////////////////////////////
// Test vectors with retire inputs and expected outputs
//////////////////////////////////////////////////
`ifndef TRAP_UNIT_TABLE_SVH
`define TRAP_UNIT_TABLE_SVH

  typedef struct {
    string     name;
    xlen_t     pc;
    logic      csr_en;
    csr_addr_t addr;
    xlen_t     wdata;
    special_t  special;
    logic      exc;
    cause_t    cause;
    logic      exp_redir;  // Expected outputs from here on
    xlen_t     exp_pc;     // Only checked with exp_redir
    logic      exp_rd;
    xlen_t     exp_data;   // Only checked with exp_rd
    priv_t     exp_priv;
  } test_vec_t;

  test_vec_t tests[$];
  integer    seed;

  task automatic add_row(input string name, input xlen_t pc, input logic csr_en,
                         input csr_addr_t addr, input xlen_t wdata, input special_t special,
                         input logic exc, input cause_t cause, input logic exp_redir,
                         input xlen_t exp_pc, input logic exp_rd, input xlen_t exp_data,
                         input priv_t exp_priv);
    test_vec_t v;
    v.name      = name;
    v.pc        = pc;
    v.csr_en    = csr_en;
    v.addr      = addr;
    v.wdata     = wdata;
    v.special   = special;
    v.exc       = exc;
    v.cause     = cause;
    v.exp_redir = exp_redir;
    v.exp_pc    = exp_pc;
    v.exp_rd    = exp_rd;
    v.exp_data  = exp_data;
    v.exp_priv  = exp_priv;
    tests.push_back(v);
  endtask

  // Legal machine-mode access whose read-back is the value before the write
  task automatic csr_row(input string name, input csr_addr_t addr, input xlen_t wdata,
                         input xlen_t old);
    add_row(name, 32'h0000_1000, 1'b1, addr, wdata, spec_none, 1'b0, 8'd0,
            1'b0, 32'h0, 1'b1, old, priv_m);
  endtask

  // Any trap lands in machine mode at the vector
  task automatic trap_row(input string name, input xlen_t pc, input logic csr_en,
                          input csr_addr_t addr, input special_t special, input logic exc,
                          input cause_t cause, input xlen_t vec);
    add_row(name, pc, csr_en, addr, 32'hdead_beef, special, exc, cause,  // Junk data never lands
            1'b1, vec, 1'b0, 32'h0, priv_m);
  endtask

  task automatic mret_row(input string name, input xlen_t pc, input xlen_t target,
                          input priv_t new_priv);
    add_row(name, pc, 1'b0, 12'h0, 32'h0, spec_mret, 1'b0, 8'd0,
            1'b1, target, 1'b0, 32'h0, new_priv);
  endtask

  task automatic fill_table();
    xlen_t r1;
    xlen_t r2;
    seed = 32'hdb80_fa28;
    r1 = $random(seed);  // mscratch payloads
    r2 = $random(seed);
    csr_row("mscratch_first", csr_mscratch, r1, 32'h0);
    csr_row("mscratch_again", csr_mscratch, r2, r1);
    trap_row("rob_fault_reset_vec", 32'h2000, 1'b0, 12'h0, spec_none, 1'b1, 8'd5, 32'h100);
    csr_row("mepc_after_fault", csr_mepc, 32'h2000, 32'h2000);
    csr_row("mcause_after_fault", csr_mcause, 32'd5, 32'd5);
    csr_row("mtvec_write", csr_mtvec, 32'h400, 32'h100);
    trap_row("rob_fault_new_vec", 32'h2100, 1'b0, 12'h0, spec_none, 1'b1, 8'd5, 32'h400);
    csr_row("mepc_second_fault", csr_mepc, 32'h2100, 32'h2100);
    trap_row("ecall_machine", 32'h2200, 1'b0, 12'h0, spec_ecall, 1'b0, 8'd0, 32'h400);
    csr_row("mcause_ecall_m", csr_mcause, 32'd11, 32'd11);
    csr_row("mstatus_mpp_user", csr_mstatus, 32'h80, 32'h1800);  // MPIE set, MPP user
    csr_row("mepc_user_entry", csr_mepc, 32'h3000, 32'h2200);
    mret_row("mret_to_user", 32'h2300, 32'h3000, priv_u);
    trap_row("ecall_user", 32'h3004, 1'b0, 12'h0, spec_ecall, 1'b0, 8'd0, 32'h400);
    csr_row("mcause_ecall_u", csr_mcause, 32'd8, 32'd8);
    csr_row("mstatus_mpp_machine", csr_mstatus, 32'h1880, 32'h80);
    mret_row("mret_to_machine", 32'h2400, 32'h3004, priv_m);
    csr_row("mstatus_after_mret", csr_mstatus, 32'h88, 32'h88);  // MIE back, MPP cleared
    csr_row("mepc_user_code", csr_mepc, 32'h5000, 32'h3004);
    mret_row("mret_to_user_again", 32'h2500, 32'h5000, priv_u);
    trap_row("csr_from_user", 32'h5004, 1'b1, csr_mscratch, spec_none, 1'b0, 8'd0, 32'h400);
    csr_row("mcause_csr_user", csr_mcause, 32'd2, 32'd2);
    csr_row("mscratch_kept", csr_mscratch, r2, r2);
    mret_row("mret_to_user_third", 32'h2600, 32'h5004, priv_u);
    trap_row("mret_from_user", 32'h5008, 1'b0, 12'h0, spec_mret, 1'b0, 8'd0, 32'h400);
    csr_row("mepc_mret_user", csr_mepc, 32'h5008, 32'h5008);
    csr_row("mcause_mret_user", csr_mcause, 32'd0, 32'd2);  // Cleared so the next trap shows
    trap_row("unimplemented_csr", 32'h2700, 1'b1, 12'h344, spec_none, 1'b0, 8'd0, 32'h400);
    csr_row("mcause_unimplemented", csr_mcause, 32'd2, 32'd2);
    add_row("plain_retire", 32'h2800, 1'b0, 12'h0, 32'h0, spec_none, 1'b0, 8'd0,
            1'b0, 32'h0, 1'b0, 32'h0, priv_m);
  endtask

`endif

//--- bench/trap_unit_tb.sv
//////////////////////////////////////////////////
// Trap unit testbench: clock, reset, table loop,
// field checks, timeout and summary
//////////////////////////////////////////////////
`default_nettype none

module trap_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import trap_pkg::*;

  localparam int reset_cycles = 10;

  logic      clk;
  logic      reset;
  logic      retire_valid;
  xlen_t     retire_pc;
  logic      retire_csr_en;
  csr_addr_t retire_csr_addr;
  xlen_t     retire_csr_wdata;
  special_t  retire_special;
  logic      retire_exception;
  cause_t    retire_cause;

  logic      redirect_valid;
  xlen_t     redirect_pc;
  logic      rd_valid;
  xlen_t     rd_data;
  priv_t     priv;

  int cycles = 0;  // Free-running, for the timeout
  int limit;
  int errors;      // All mismatches
  int failed;      // Tests with any mismatch

  `include "trap_unit_table.svh"

  trap_unit #(.MTVEC_RESET(32'h0000_0100)) trap_unit_i (
    .clk, .reset,
    .retire_valid, .retire_pc, .retire_csr_en, .retire_csr_addr,
    .retire_csr_wdata, .retire_special, .retire_exception, .retire_cause,
    .redirect_valid, .redirect_pc, .rd_valid, .rd_data, .priv
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: outputs never completed");
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Returns 1 on a wrong value
  function automatic int check_field(input string test, input string field,
                                     input xlen_t expected, input xlen_t actual);
    int bad;
    bad = 0;
    assert (actual === expected) else begin
      $display("mismatch %s %s expected %h actual %h", test, field, expected, actual);
      bad = 1;
    end
    return bad;
  endfunction

  task automatic apply_row(input test_vec_t t);
    int bad;
    bad = 0;
    @(posedge clk);
    retire_valid     <= 1'b1;
    retire_pc        <= t.pc;
    retire_csr_en    <= t.csr_en;
    retire_csr_addr  <= t.addr;
    retire_csr_wdata <= t.wdata;
    retire_special   <= t.special;
    retire_exception <= t.exc;
    retire_cause     <= t.cause;
    @(posedge clk);
    retire_valid <= 1'b0;  // Two idle cycles follow
    @(posedge clk);
    @(negedge clk);        // Mid-cycle of N+2, outputs stable
    bad += check_field(t.name, "redirect_valid", 32'(t.exp_redir), 32'(redirect_valid));
    if (t.exp_redir)
      bad += check_field(t.name, "redirect_pc", t.exp_pc, redirect_pc);
    bad += check_field(t.name, "rd_valid", 32'(t.exp_rd), 32'(rd_valid));
    if (t.exp_rd)
      bad += check_field(t.name, "rd_data", t.exp_data, rd_data);
    bad += check_field(t.name, "priv", 32'(t.exp_priv), 32'(priv));  // Level after the op
    if (bad == 0)
      $display("test %s ok", t.name);
    else
      $display("test %s had %0d mismatches", t.name, bad);
    errors += bad;
    if (bad != 0)
      failed++;
  endtask

  initial begin
    reset            <= 1'b1;
    retire_valid     <= 1'b0;
    retire_pc        <= '0;
    retire_csr_en    <= 1'b0;
    retire_csr_addr  <= '0;
    retire_csr_wdata <= '0;
    retire_special   <= spec_none;
    retire_exception <= 1'b0;
    retire_cause     <= '0;
    errors = 0;
    failed = 0;
    fill_table();
    limit = tests.size() * 3 + reset_cycles + 20;  // Three cycles per row plus margin
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    foreach (tests[i])
      apply_row(tests[i]);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             tests.size(), tests.size() - failed, failed, errors);
    if (failed == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/trap_unit.sv
//////////////////////////////////////////////////
// Trap unit top: decode, CSR file and redirect stages
//////////////////////////////////////////////////
`default_nettype none

module trap_unit #(
  parameter trap_pkg::xlen_t MTVEC_RESET = 32'h0
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                retire_valid,
  input  wire trap_pkg::xlen_t     retire_pc,
  input  wire logic                retire_csr_en,
  input  wire trap_pkg::csr_addr_t retire_csr_addr,
  input  wire trap_pkg::xlen_t     retire_csr_wdata,
  input  wire trap_pkg::special_t  retire_special,
  input  wire logic                retire_exception,
  input  wire trap_pkg::cause_t    retire_cause,
  output logic                     redirect_valid,
  output trap_pkg::xlen_t          redirect_pc,
  output logic                     rd_valid,
  output trap_pkg::xlen_t          rd_data,
  output trap_pkg::priv_t          priv
);
  import trap_pkg::*;

  // Stage 1 to stage 2
  logic      op_valid;
  xlen_t     op_pc;
  logic      op_csr_write;
  csr_slot_t op_slot;
  xlen_t     op_wdata;
  logic      op_mret;
  logic      op_trap;
  cause_t    op_cause;
  priv_t     curr_priv;

  // Stage 2 to stage 3
  xlen_t csr_rdata;
  xlen_t mtvec_value;
  xlen_t mepc_value;
  logic  s2_valid, s2_csr, s2_trap, s2_mret;

  commit_decode commit_decode_i (
    .clk, .reset,
    .retire_valid, .retire_pc, .retire_csr_en, .retire_csr_addr,
    .retire_csr_wdata, .retire_special, .retire_exception, .retire_cause,
    .curr_priv,
    .op_valid, .op_pc, .op_csr_write, .op_slot, .op_wdata,
    .op_mret, .op_trap, .op_cause
  );

  csr_file #(.MTVEC_RESET(MTVEC_RESET)) csr_file_i (
    .clk, .reset,
    .op_valid, .op_pc, .op_csr_write, .op_slot, .op_wdata,
    .op_mret, .op_trap, .op_cause,
    .csr_rdata, .mtvec_value, .mepc_value, .curr_priv,
    .out_valid(s2_valid), .out_csr(s2_csr), .out_trap(s2_trap), .out_mret(s2_mret)
  );

  trap_redirect trap_redirect_i (
    .clk, .reset,
    .s2_valid, .s2_csr, .s2_trap, .s2_mret,
    .csr_rdata, .mtvec_value, .mepc_value,
    .redirect_valid, .redirect_pc, .rd_valid, .rd_data
  );

  assign priv = curr_priv;  // Live level, updated at end of stage 2

endmodule

`default_nettype wire

//--- hdl/trap_redirect.sv
//////////////////////////////////////////////////
// Stage 3: registered fetch redirect and CSR read-back
//////////////////////////////////////////////////
`default_nettype none

module trap_redirect (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            s2_valid,
  input  wire logic            s2_csr,
  input  wire logic            s2_trap,
  input  wire logic            s2_mret,
  input  wire trap_pkg::xlen_t csr_rdata,
  input  wire trap_pkg::xlen_t mtvec_value,
  input  wire trap_pkg::xlen_t mepc_value,
  output logic                 redirect_valid,
  output trap_pkg::xlen_t      redirect_pc,
  output logic                 rd_valid,
  output trap_pkg::xlen_t      rd_data
);
  import trap_pkg::*;

  logic  redirect_next;
  xlen_t target;  // Trap vector or return address

  assign redirect_next = s2_valid && (s2_trap || s2_mret);
  assign target        = s2_trap ? mtvec_value : mepc_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      redirect_valid <= 1'b0;
      redirect_pc    <= '0;
    end else begin
      redirect_valid <= redirect_next;  // One-cycle strobe
      if (redirect_next)
        redirect_pc <= target;
    end
  end

  // Read-back of the value before the write
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end else begin
      rd_valid <= s2_valid && s2_csr;
      if (s2_valid && s2_csr)
        rd_data <= csr_rdata;
    end
  end

endmodule

`default_nettype wire

//--- csr/csr_file.sv
//////////////////////////////////////////////////
// Stage 2: machine CSR storage, privilege level,
// trap entry, mret return and combinational read
//////////////////////////////////////////////////
`default_nettype none

module csr_file #(
  parameter trap_pkg::xlen_t MTVEC_RESET = 32'h0
) (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                op_valid,
  input  wire trap_pkg::xlen_t     op_pc,
  input  wire logic                op_csr_write,
  input  wire trap_pkg::csr_slot_t op_slot,
  input  wire trap_pkg::xlen_t     op_wdata,
  input  wire logic                op_mret,
  input  wire logic                op_trap,
  input  wire trap_pkg::cause_t    op_cause,
  output trap_pkg::xlen_t          csr_rdata,
  output trap_pkg::xlen_t          mtvec_value,
  output trap_pkg::xlen_t          mepc_value,
  output trap_pkg::priv_t          curr_priv,
  output logic                     out_valid,
  output logic                     out_csr,
  output logic                     out_trap,
  output logic                     out_mret
);
  import trap_pkg::*;

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mscratch;
  priv_t priv_q;

  logic [1:0] mpp;
  priv_t      mret_priv;  // Level restored by mret

  assign mpp       = mstatus[mpp_lo +: 2];
  assign mret_priv = (mpp == priv_m) ? priv_m : priv_u;  // Only U and M exist

  // Old value of the addressed CSR
  always_comb begin
    case (op_slot)
      slot_mstatus:  csr_rdata = mstatus;
      slot_mtvec:    csr_rdata = mtvec;
      slot_mepc:     csr_rdata = mepc;
      slot_mcause:   csr_rdata = mcause;
      slot_mscratch: csr_rdata = mscratch;
      default:       csr_rdata = '0;
    endcase
  end

  assign mtvec_value = mtvec;  // Pre-update target for this cycle's trap
  assign mepc_value  = mepc;
  assign curr_priv   = priv_q;

  // Stage-2 strobes toward redirect
  assign out_valid = op_valid;
  assign out_csr   = op_csr_write;
  assign out_trap  = op_trap;
  assign out_mret  = op_mret;

  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus  <= '0;
      mtvec    <= MTVEC_RESET;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
      priv_q   <= priv_m;
    end else if (op_trap) begin
      // Trap entry
      mepc                  <= op_pc;
      mcause                <= {{($bits(xlen_t) - $bits(cause_t)){1'b0}}, op_cause};
      mstatus[mpie_bit]     <= mstatus[mie_bit];
      mstatus[mie_bit]      <= 1'b0;
      mstatus[mpp_lo +: 2]  <= priv_q;  // Remember where we came from
      priv_q                <= priv_m;
    end else if (op_mret) begin
      priv_q                <= mret_priv;
      mstatus[mie_bit]      <= mstatus[mpie_bit];
      mstatus[mpie_bit]     <= 1'b1;
      mstatus[mpp_lo +: 2]  <= priv_u;
    end else if (op_csr_write) begin
      case (op_slot)
        slot_mstatus:  mstatus  <= op_wdata;
        slot_mtvec:    mtvec    <= op_wdata;
        slot_mepc:     mepc     <= op_wdata;
        slot_mcause:   mcause   <= op_wdata;
        slot_mscratch: mscratch <= op_wdata;
        default: begin
          // Unused slots never reach here, decode traps them
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/commit_decode.sv
//////////////////////////////////////////////////
// Stage 1: retire register and trap/CSR/mret classification
//////////////////////////////////////////////////
`default_nettype none

module commit_decode (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                retire_valid,
  input  wire trap_pkg::xlen_t     retire_pc,
  input  wire logic                retire_csr_en,
  input  wire trap_pkg::csr_addr_t retire_csr_addr,
  input  wire trap_pkg::xlen_t     retire_csr_wdata,
  input  wire trap_pkg::special_t  retire_special,
  input  wire logic                retire_exception,
  input  wire trap_pkg::cause_t    retire_cause,
  input  wire trap_pkg::priv_t     curr_priv,
  output logic                     op_valid,
  output trap_pkg::xlen_t          op_pc,
  output logic                     op_csr_write,
  output trap_pkg::csr_slot_t      op_slot,
  output trap_pkg::xlen_t          op_wdata,
  output logic                     op_mret,
  output logic                     op_trap,
  output trap_pkg::cause_t         op_cause
);
  import trap_pkg::*;

  logic      valid_q;
  logic      csr_en_q;
  csr_addr_t addr_q;
  special_t  special_q;
  logic      exc_q;
  cause_t    cause_q;

  logic      addr_hit;     // CSR address implemented
  logic      is_user;
  logic      is_ecall;
  logic      is_mret;
  logic      csr_illegal;  // User access or unknown address
  logic      mret_illegal;

  always_ff @(posedge clk) begin
    if (reset) valid_q <= 1'b0;
    else       valid_q <= retire_valid;
  end

  // Payload, only meaningful with valid_q
  always_ff @(posedge clk) begin
    op_pc     <= retire_pc;
    csr_en_q  <= retire_csr_en;
    addr_q    <= retire_csr_addr;
    op_wdata  <= retire_csr_wdata;
    special_q <= retire_special;
    exc_q     <= retire_exception;
    cause_q   <= retire_cause;
  end

  always_comb begin
    op_slot      = csr_slot_of(addr_q, addr_hit);
    is_user      = (curr_priv == priv_u);  // Privilege as of this cycle
    is_ecall     = (special_q == spec_ecall);
    is_mret      = (special_q == spec_mret);
    csr_illegal  = csr_en_q && (is_user || !addr_hit);
    mret_illegal = is_mret && is_user;

    op_valid = valid_q;
    op_trap  = valid_q && (exc_q || is_ecall || csr_illegal || mret_illegal);

    // ROB fault wins, then ecall, then illegal access
    if (exc_q)
      op_cause = cause_q;
    else if (is_ecall)
      op_cause = is_user ? cause_ecall_u : cause_ecall_m;
    else
      op_cause = cause_illegal;

    // Legal ops only when nothing above traps
    op_csr_write = valid_q && csr_en_q && !op_trap;
    op_mret      = valid_q && is_mret && !op_trap;
  end

endmodule

`default_nettype wire

//--- common/trap_pkg.sv
//////////////////////////////////////////////////
// Trap unit package: widths, privilege and special-op enums,
// CSR addresses, cause codes, CSR address-to-slot lookup
//////////////////////////////////////////////////
`default_nettype none

package trap_pkg;

  typedef logic [31:0] xlen_t;      // Data or address word
  typedef logic [11:0] csr_addr_t;  // CSR address field
  typedef logic [2:0]  csr_slot_t;  // Index into implemented CSRs
  typedef logic [7:0]  cause_t;     // Trap cause code

  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_m = 2'd3
  } priv_t;

  typedef enum logic [1:0] {
    spec_none  = 2'd0,
    spec_ecall = 2'd1,
    spec_mret  = 2'd2
  } special_t;

  // Implemented machine-mode CSRs
  localparam csr_addr_t csr_mstatus  = 12'h300;
  localparam csr_addr_t csr_mtvec    = 12'h305;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc     = 12'h341;
  localparam csr_addr_t csr_mcause   = 12'h342;

  // Storage slots, one per implemented CSR
  localparam csr_slot_t slot_mstatus  = 3'd0;
  localparam csr_slot_t slot_mtvec    = 3'd1;
  localparam csr_slot_t slot_mepc     = 3'd2;
  localparam csr_slot_t slot_mcause   = 3'd3;
  localparam csr_slot_t slot_mscratch = 3'd4;

  localparam cause_t cause_illegal = 8'd2;
  localparam cause_t cause_ecall_u = 8'd8;
  localparam cause_t cause_ecall_m = 8'd11;

  // mstatus fields
  localparam int mie_bit  = 3;
  localparam int mpie_bit = 7;
  localparam int mpp_lo   = 11;  // MPP is [12:11]

  // Slot of an address; hit low when the CSR is not implemented
  function automatic csr_slot_t csr_slot_of(input csr_addr_t addr, output logic hit);
    hit = 1'b1;
    case (addr)
      csr_mstatus:  csr_slot_of = slot_mstatus;
      csr_mtvec:    csr_slot_of = slot_mtvec;
      csr_mepc:     csr_slot_of = slot_mepc;
      csr_mcause:   csr_slot_of = slot_mcause;
      csr_mscratch: csr_slot_of = slot_mscratch;
      default: begin
        csr_slot_of = slot_mstatus;
        hit = 1'b0;
      end
    endcase
  endfunction

endpackage

`default_nettype wire
